//--- hdl/vtp_pkg.sv
// Shared widths, localparams and structs for the VTP translation shim
// Virtual and physical addresses are 48 bits with 4 KB base pages
// Page table lines are 512 bits and hold eight 64-bit entries each
// Only 4 KB and 2 MB translations exist, so a 1 GB leaf counts as malformed

`default_nettype none

package vtp_pkg;

    // ====================
    // Address geometry
    // ====================

    localparam int VA_WIDTH = 48;
    localparam int PA_WIDTH = 48;
    localparam int PAGE_OFFSET_WIDTH = 12;
    localparam int LINE_DATA_WIDTH = 512;
    localparam int LINE_OFFSET_WIDTH = $clog2(LINE_DATA_WIDTH / 8);
    localparam int LINE_ADDR_WIDTH = PA_WIDTH - LINE_OFFSET_WIDTH;
    localparam int VA_PAGE_IDX_WIDTH = VA_WIDTH - PAGE_OFFSET_WIDTH;
    localparam int PA_PAGE_IDX_WIDTH = PA_WIDTH - PAGE_OFFSET_WIDTH;

    // Radix table with 512 entries of 64 bits per 4 KB page
    localparam int PTE_WIDTH = 64;
    localparam int PT_WORDS_PER_LINE = LINE_DATA_WIDTH / PTE_WIDTH;
    localparam int PT_IDX_WIDTH = 9;
    localparam int PT_WORD_IDX_WIDTH = $clog2(PT_WORDS_PER_LINE);
    localparam int PT_LINE_IDX_WIDTH = PT_IDX_WIDTH - PT_WORD_IDX_WIDTH;
    localparam int PT_MAX_DEPTH = 4;
    localparam int PT_DEPTH_WIDTH = $clog2(PT_MAX_DEPTH);

    localparam int TLB_ENTRIES = 4;

    typedef logic [VA_PAGE_IDX_WIDTH-1:0] va_page_idx_t;
    typedef logic [PA_PAGE_IDX_WIDTH-1:0] pa_page_idx_t;
    typedef logic [LINE_ADDR_WIDTH-1:0] line_addr_t;
    typedef logic [LINE_DATA_WIDTH-1:0] line_data_t;
    typedef logic [PT_DEPTH_WIDTH-1:0] pt_depth_t;

    // Depth of the read that returns a leaf of each page size
    localparam pt_depth_t PT_DEPTH_4KB = pt_depth_t'(PT_MAX_DEPTH - 1);
    localparam pt_depth_t PT_DEPTH_2MB = pt_depth_t'(PT_MAX_DEPTH - 2);

    // ====================
    // Structs
    // ====================

    // Software fills unused entries with all ones, so invalid is set there
    typedef struct packed {
        logic [PTE_WIDTH-LINE_ADDR_WIDTH-LINE_OFFSET_WIDTH-1:0] unused;
        line_addr_t line_addr;
        logic [LINE_OFFSET_WIDTH-3:0] spare;
        logic invalid;
        logic terminal;
    } pte_t;

    typedef struct packed {
        line_addr_t page_table_base;
        logic base_valid;
        logic enabled;
    } vtp_csr_t;

    typedef struct packed {
        logic [VA_WIDTH-1:0] va;
    } xlate_req_t;

    typedef struct packed {
        pa_page_idx_t pa_page;
        logic big_page;
        logic not_present;
    } xlate_rsp_t;

    typedef struct packed {
        va_page_idx_t va_page;
        pa_page_idx_t pa_page;
        logic big_page;
    } tlb_fill_t;

    typedef struct packed {
        line_addr_t line_addr;
    } pt_read_req_t;

endpackage

`default_nettype wire

//--- hdl/vtp_pt_walk.sv
// Hardware page table walker behind the TLB
// Walks a four level radix table that software builds in shared memory
// Handles one walk at a time and keeps at most one line read in flight
// Configuration must be static while enabled
// A missing or malformed entry sets not_present, which only reset clears

`timescale 1ns/10ps
`default_nettype none

module vtp_pt_walk
(
    input  wire logic clk,
    input  wire logic reset,
    input  wire vtp_pkg::vtp_csr_t csr,

    // Walk request from the TLB
    input  wire logic walk_req_en,
    input  wire vtp_pkg::va_page_idx_t walk_req_va,
    output logic walk_req_rdy,

    // Translation result back to the TLB
    output logic fill_en,
    output vtp_pkg::tlb_fill_t fill,
    input  wire logic fill_rdy,
    output logic not_present,

    // Line reads from the page table
    output logic pt_read_en,
    output vtp_pkg::pt_read_req_t pt_read_req,
    input  wire logic pt_read_rdy,
    input  wire logic pt_read_data_en,
    input  wire vtp_pkg::line_data_t pt_read_data
);

    // Index into one table page, split into line and word within line
    typedef struct packed {
        logic [vtp_pkg::PT_LINE_IDX_WIDTH-1:0] line_idx;
        logic [vtp_pkg::PT_WORD_IDX_WIDTH-1:0] word_idx;
    } pt_idx_t;

    typedef enum logic [1:0]
    {
        ST_IDLE,
        ST_START,
        ST_BUSY
    } state_t;

    state_t state;
    logic initialized;
    logic error;
    logic read_outstanding;

    // Registered response of the latest table read
    logic rsp_valid;
    logic rsp_found;
    vtp_pkg::line_addr_t rsp_line;

    // VA under translation and its shifting index copy
    vtp_pkg::va_page_idx_t walk_va;
    vtp_pkg::va_page_idx_t walk_va_idx;
    vtp_pkg::pt_depth_t depth;
    logic [vtp_pkg::PT_WORD_IDX_WIDTH-1:0] word_idx;
    pt_idx_t next_idx;

    vtp_pkg::pte_t [vtp_pkg::PT_WORDS_PER_LINE-1:0] rsp_words;
    vtp_pkg::pte_t rsp_entry;
    logic entry_bad;

    // ====================
    // Control
    // ====================

    // The table root is trusted one cycle after it is valid and enabled
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            initialized <= 1'b0;
        end
        else
        begin
            initialized <= csr.base_valid && csr.enabled;
        end
    end

    assign walk_req_rdy = initialized && (state == ST_IDLE) && !error;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= ST_IDLE;
        end
        else
        begin
            case (state)
                ST_IDLE:
                begin
                    if (walk_req_en && walk_req_rdy)
                    begin
                        state <= ST_START;
                    end
                end
                ST_START:
                begin
                    if (pt_read_en)
                    begin
                        state <= ST_BUSY;
                    end
                end
                default:
                begin
                    // A walk ends with a fill or with the sticky error
                    if (fill_en || error)
                    begin
                        state <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    // The top 9 bits of the shifted VA index the current level
    assign next_idx = walk_va_idx[vtp_pkg::VA_PAGE_IDX_WIDTH-1 -: vtp_pkg::PT_IDX_WIDTH];

    // Depth starts at all ones so the first read lands on level 0
    always_ff @(posedge clk)
    begin
        if (walk_req_en && walk_req_rdy)
        begin
            walk_va <= walk_req_va;
            walk_va_idx <= walk_req_va;
            depth <= '1;
        end
        else if (pt_read_en)
        begin
            word_idx <= next_idx.word_idx;
            walk_va_idx <= walk_va_idx << vtp_pkg::PT_IDX_WIDTH;
            depth <= depth + 1'b1;
        end
    end

    // ====================
    // Read requests
    // ====================

    // A low rdy holds everything, so the address stays stable
    always_comb
    begin
        pt_read_en = 1'b0;
        if ((state == ST_START) ||
            ((state == ST_BUSY) && rsp_valid && !rsp_found && !error))
        begin
            pt_read_en = pt_read_rdy;
        end
    end

    // Root or previous pointer, with the line index of this level spliced in
    always_comb
    begin
        pt_read_req.line_addr = (state == ST_START) ? csr.page_table_base : rsp_line;
        pt_read_req.line_addr[vtp_pkg::PT_LINE_IDX_WIDTH-1:0] = next_idx.line_idx;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            read_outstanding <= 1'b0;
        end
        else if (pt_read_en)
        begin
            read_outstanding <= 1'b1;
        end
        else if (pt_read_data_en)
        begin
            read_outstanding <= 1'b0;
        end
    end

    // ====================
    // Responses
    // ====================

    assign rsp_words = pt_read_data;
    assign rsp_entry = rsp_words[word_idx];

    // Invalid entries, pointers past the last level and 1 GB leaves are errors
    always_comb
    begin
        entry_bad = rsp_entry.invalid;
        if (!rsp_entry.terminal && (depth == vtp_pkg::PT_DEPTH_4KB))
        begin
            entry_bad = 1'b1;
        end
        if (rsp_entry.terminal && (depth != vtp_pkg::PT_DEPTH_4KB) &&
            (depth != vtp_pkg::PT_DEPTH_2MB))
        begin
            entry_bad = 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rsp_valid <= 1'b0;
            rsp_found <= 1'b0;
            error <= 1'b0;
        end
        else if (pt_read_data_en)
        begin
            rsp_valid <= 1'b1;
            rsp_found <= rsp_entry.terminal && !entry_bad;
            error <= error || entry_bad;
        end
        else if (fill_en || pt_read_en)
        begin
            // The response has been consumed
            rsp_valid <= 1'b0;
            rsp_found <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (pt_read_data_en)
        begin
            rsp_line <= rsp_entry.line_addr;
        end
    end

    // Fill goes out the cycle after the terminal response
    assign fill_en = rsp_found && fill_rdy;
    assign fill.va_page = walk_va;
    assign fill.pa_page = rsp_line[vtp_pkg::LINE_ADDR_WIDTH-1 -: vtp_pkg::PA_PAGE_IDX_WIDTH];
    assign fill.big_page = (depth == vtp_pkg::PT_DEPTH_2MB);
    assign not_present = error;

    // Memory sees at most one read in flight, and never a stray response
    a_single_read: assert property (@(posedge clk) disable iff (reset)
        pt_read_en |-> !read_outstanding);
    a_rsp_expected: assert property (@(posedge clk) disable iff (reset)
        pt_read_data_en |-> read_outstanding);

endmodule

`default_nettype wire

//--- hdl/vtp_tlb.sv
// Four entry fully associative TLB with a four-phase client port
// Hits ack two cycles after req is seen, misses after the walk completes
// Only one miss is handled at a time, and there is no invalidation
// A 2 MB entry passes the low 9 page bits of the VA through

`timescale 1ns/10ps
`default_nettype none

module vtp_tlb
(
    input  wire logic clk,
    input  wire logic reset,

    // Client side
    input  wire logic xlate_req,
    input  wire vtp_pkg::xlate_req_t xlate_req_data,
    output logic xlate_ack,
    output vtp_pkg::xlate_rsp_t xlate_rsp,

    // Walker side
    output logic walk_req_en,
    output vtp_pkg::va_page_idx_t walk_req_va,
    input  wire logic walk_req_rdy,
    input  wire logic fill_en,
    input  wire vtp_pkg::tlb_fill_t fill,
    output logic fill_rdy,
    input  wire logic not_present
);

    typedef struct packed {
        logic big_page;
        vtp_pkg::va_page_idx_t va_page;
        vtp_pkg::pa_page_idx_t pa_page;
    } tlb_entry_t;

    typedef enum logic [2:0]
    {
        ST_IDLE,
        ST_LOOKUP,
        ST_DECIDE,
        ST_MISS,
        ST_FILL,
        ST_ACK
    } state_t;

    state_t state;
    tlb_entry_t [vtp_pkg::TLB_ENTRIES-1:0] entries;
    logic [vtp_pkg::TLB_ENTRIES-1:0] entry_valid;
    logic [$clog2(vtp_pkg::TLB_ENTRIES)-1:0] victim;
    vtp_pkg::va_page_idx_t req_va;

    logic lookup_hit;
    vtp_pkg::pa_page_idx_t lookup_pa;
    logic lookup_big;
    logic hit_q;
    vtp_pkg::pa_page_idx_t hit_pa_q;
    logic hit_big_q;

    // Big pages take their low 9 page bits from the VA
    function automatic vtp_pkg::pa_page_idx_t page_pa(vtp_pkg::pa_page_idx_t pa,
                                                      logic big,
                                                      vtp_pkg::va_page_idx_t va);
        vtp_pkg::pa_page_idx_t result;
        result = pa;
        if (big)
        begin
            result[vtp_pkg::PT_IDX_WIDTH-1:0] = va[vtp_pkg::PT_IDX_WIDTH-1:0];
        end
        return result;
    endfunction

    // ====================
    // Lookup
    // ====================

    // First matching entry wins; the tag compare skips low bits of big pages
    always_comb
    begin
        lookup_hit = 1'b0;
        lookup_pa = '0;
        lookup_big = 1'b0;
        for (int i = 0; i < vtp_pkg::TLB_ENTRIES; i++)
        begin
            if (entry_valid[i] && !lookup_hit &&
                ((entries[i].va_page[vtp_pkg::VA_PAGE_IDX_WIDTH-1:vtp_pkg::PT_IDX_WIDTH] ==
                  req_va[vtp_pkg::VA_PAGE_IDX_WIDTH-1:vtp_pkg::PT_IDX_WIDTH]) &&
                 (entries[i].big_page ||
                  (entries[i].va_page[vtp_pkg::PT_IDX_WIDTH-1:0] ==
                   req_va[vtp_pkg::PT_IDX_WIDTH-1:0]))))
            begin
                lookup_hit = 1'b1;
                lookup_pa = page_pa(entries[i].pa_page, entries[i].big_page, req_va);
                lookup_big = entries[i].big_page;
            end
        end
    end

    // Lookup result is registered, DECIDE always follows LOOKUP
    always_ff @(posedge clk)
    begin
        if (state == ST_LOOKUP)
        begin
            hit_q <= lookup_hit;
            hit_pa_q <= lookup_pa;
            hit_big_q <= lookup_big;
        end
    end

    assign walk_req_en = (state == ST_MISS) && !not_present;
    assign walk_req_va = req_va;
    assign fill_rdy = (state == ST_FILL);

    // ====================
    // Handshake FSM
    // ====================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= ST_IDLE;
            xlate_ack <= 1'b0;
            entry_valid <= '0;
            victim <= '0;
        end
        else
        begin
            case (state)
                ST_IDLE:
                begin
                    if (xlate_req)
                    begin
                        req_va <= xlate_req_data.va[vtp_pkg::VA_WIDTH-1 -:
                                                    vtp_pkg::VA_PAGE_IDX_WIDTH];
                        state <= ST_LOOKUP;
                    end
                end
                ST_LOOKUP:
                begin
                    state <= ST_DECIDE;
                end
                ST_DECIDE:
                begin
                    // Hits still translate after the walker has failed
                    if (hit_q)
                    begin
                        xlate_rsp <= '{pa_page: hit_pa_q, big_page: hit_big_q,
                                       not_present: 1'b0};
                        xlate_ack <= 1'b1;
                        state <= ST_ACK;
                    end
                    else if (not_present)
                    begin
                        xlate_rsp <= '{pa_page: '0, big_page: 1'b0, not_present: 1'b1};
                        xlate_ack <= 1'b1;
                        state <= ST_ACK;
                    end
                    else
                    begin
                        state <= ST_MISS;
                    end
                end
                ST_MISS:
                begin
                    if (not_present)
                    begin
                        xlate_rsp <= '{pa_page: '0, big_page: 1'b0, not_present: 1'b1};
                        xlate_ack <= 1'b1;
                        state <= ST_ACK;
                    end
                    else if (walk_req_rdy)
                    begin
                        state <= ST_FILL;
                    end
                end
                ST_FILL:
                begin
                    if (fill_en)
                    begin
                        entry_valid[victim] <= 1'b1;
                        victim <= victim + 1'b1;
                        xlate_rsp <= '{pa_page: page_pa(fill.pa_page, fill.big_page, req_va),
                                       big_page: fill.big_page, not_present: 1'b0};
                        xlate_ack <= 1'b1;
                        state <= ST_ACK;
                    end
                    else if (not_present)
                    begin
                        // Failed walk leaves the entry set as it was
                        xlate_rsp <= '{pa_page: '0, big_page: 1'b0, not_present: 1'b1};
                        xlate_ack <= 1'b1;
                        state <= ST_ACK;
                    end
                end
                default:
                begin
                    if (!xlate_req)
                    begin
                        xlate_ack <= 1'b0;
                        state <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    // Round-robin victim takes the walker's result
    always_ff @(posedge clk)
    begin
        if (fill_en && fill_rdy)
        begin
            entries[victim] <= '{big_page: fill.big_page, va_page: fill.va_page,
                                 pa_page: fill.pa_page};
        end
    end

    // Client keeps req up until the TLB has answered
    a_req_held: assert property (@(posedge clk) disable iff (reset)
        xlate_req && !xlate_ack |=> xlate_req);

endmodule

`default_nettype wire

//--- hdl/vtp_top.sv
// VTP translation shim top level
// Client uses a four-phase req/ack handshake, memory uses en/rdy reads
// Configuration is static and enables walks one cycle after it is valid

`timescale 1ns/10ps
`default_nettype none

module vtp_top
(
    input  wire logic clk,
    input  wire logic reset,
    input  wire vtp_pkg::vtp_csr_t csr,

    input  wire logic xlate_req,
    input  wire vtp_pkg::xlate_req_t xlate_req_data,
    output logic xlate_ack,
    output vtp_pkg::xlate_rsp_t xlate_rsp,

    output logic pt_read_en,
    output vtp_pkg::pt_read_req_t pt_read_req,
    input  wire logic pt_read_rdy,
    input  wire logic pt_read_data_en,
    input  wire vtp_pkg::line_data_t pt_read_data
);

    // TLB to walker links
    logic walk_req_en;
    vtp_pkg::va_page_idx_t walk_req_va;
    logic walk_req_rdy;
    logic fill_en;
    vtp_pkg::tlb_fill_t fill;
    logic fill_rdy;
    logic not_present;

    vtp_tlb i_tlb
    (
        .clk, .reset, .xlate_req, .xlate_req_data, .xlate_ack, .xlate_rsp,
        .walk_req_en, .walk_req_va, .walk_req_rdy, .fill_en, .fill, .fill_rdy,
        .not_present
    );

    vtp_pt_walk i_pt_walk
    (
        .clk, .reset, .csr, .walk_req_en, .walk_req_va, .walk_req_rdy,
        .fill_en, .fill, .fill_rdy, .not_present, .pt_read_en, .pt_read_req,
        .pt_read_rdy, .pt_read_data_en, .pt_read_data
    );

endmodule

`default_nettype wire

//--- tb/pt_mem_model.sv
// Page table memory for the testbench, stored as a sparse array of 512-bit lines
// Lines that were never written read back as all ones, which decodes as invalid
// Accepts one read at a time and answers 1 to 6 cycles later, in order
// Ready drops at random, and the random stream comes from a fixed xorshift seed
// Outputs change 1 ns after the rising clock edge

`timescale 1ns/10ps
`default_nettype none

module pt_mem_model
(
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic read_en,
    input  wire vtp_pkg::pt_read_req_t read_req,
    output logic read_rdy,
    output logic read_data_en,
    output vtp_pkg::line_data_t read_data
);

    localparam logic [31:0] SEED = 32'h7127b65d;
    localparam int MAX_DELAY = 6;

    vtp_pkg::line_data_t lines [vtp_pkg::line_addr_t];
    logic [31:0] rng;
    logic accept;
    logic pending;
    vtp_pkg::line_addr_t pending_addr;
    int unsigned wait_cycles;

    function automatic logic [31:0] xorshift32(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Writes one 64-bit entry and keeps the other words of the line
    task automatic set_entry(vtp_pkg::line_addr_t line, logic [2:0] word, vtp_pkg::pte_t entry);
        vtp_pkg::pte_t [vtp_pkg::PT_WORDS_PER_LINE-1:0] words;
        if (lines.exists(line))
        begin
            words = lines[line];
        end
        else
        begin
            words = '1;
        end
        words[word] = entry;
        lines[line] = words;
    endtask

    initial
    begin
        rng = SEED;
        read_rdy = 1'b0;
        read_data_en = 1'b0;
        read_data = '1;
        pending = 1'b0;
        pending_addr = '0;
        wait_cycles = 0;
        forever
        begin
            // The handshake is sampled mid-cycle where both sides are stable
            @(negedge clk);
            accept = !reset && read_en && read_rdy;
            if (accept)
            begin
                pending_addr = read_req.line_addr;
            end
            @(posedge clk);
            #1;
            read_data_en = 1'b0;
            if (reset)
            begin
                pending = 1'b0;
                read_rdy = 1'b0;
            end
            else
            begin
                if (accept)
                begin
                    rng = xorshift32(rng);
                    pending = 1'b1;
                    wait_cycles = 1 + (rng % MAX_DELAY);
                end
                // A delay of one puts the data in the cycle right after the read
                if (pending)
                begin
                    wait_cycles--;
                    if (wait_cycles == 0)
                    begin
                        read_data_en = 1'b1;
                        read_data = lines.exists(pending_addr) ? lines[pending_addr] : '1;
                        pending = 1'b0;
                    end
                end
                // Ready is low about one cycle in four
                rng = xorshift32(rng);
                read_rdy = (rng[1:0] != 2'b00);
            end
        end
    end

endmodule

`default_nettype wire

//--- tb/tb_vtp_top.sv
// Testbench for the VTP translation shim
// Builds a four level page table for six VAs, then runs a table of translations
// Expected PAs and read addresses come from the table image built here
// Stops at the first error; a watchdog bounds the whole run

`timescale 1ns/10ps
`default_nettype none

module tb_vtp_top;

    localparam int CLK_PERIOD = 20;
    localparam int NUM_VAS = 6;
    localparam int NUM_ROWS = 11;
    localparam int CYCLES_PER_ROW = 200;
    localparam int HIT_LATENCY = 2;
    localparam logic [31:0] SEED = 32'h7127b65d;

    localparam int KIND_4KB = 0;
    localparam int KIND_2MB = 1;
    localparam int KIND_BAD = 2;

    // Root table page, and one page per level and VA above TABLE_PAGE_BASE
    localparam vtp_pkg::pa_page_idx_t ROOT_PAGE = 36'h100;
    localparam int TABLE_PAGE_BASE = 32'h200;

    // Top VA bits differ so no two VAs share a root entry
    localparam logic [47:0] TEST_VA [NUM_VAS] = '{
        48'h01a5_c3e7_1234, 48'h1234_5678_9abc, 48'h2345_6789_0abc,
        48'h3456_789a_bcde, 48'h4567_89ab_cdef, 48'h5678_9abc_def0
    };
    localparam int TEST_KIND [NUM_VAS] = '{
        KIND_4KB, KIND_2MB, KIND_4KB, KIND_4KB, KIND_4KB, KIND_BAD
    };

    // Same 2 MB region as TEST_VA[1] with other low 9 page bits
    localparam logic [47:0] VA_2MB_ALIAS = 48'h1234_5670_4def;
    localparam logic [47:0] VA_UNMAPPED = 48'h7fed_cba9_8765;

    typedef struct packed {
        logic [47:0] va;
        logic [2:0] vid;
        logic walk;
        vtp_pkg::xlate_rsp_t exp;
    } row_t;

    logic clk = 1'b0;
    logic reset;
    vtp_pkg::vtp_csr_t csr;
    logic xlate_req;
    vtp_pkg::xlate_req_t xlate_req_data;
    logic xlate_ack;
    vtp_pkg::xlate_rsp_t xlate_rsp;
    logic pt_read_en;
    vtp_pkg::pt_read_req_t pt_read_req;
    logic pt_read_rdy;
    logic pt_read_data_en;
    vtp_pkg::line_data_t pt_read_data;

    vtp_pkg::pa_page_idx_t pa_list [NUM_VAS];
    row_t rows [NUM_ROWS];
    vtp_pkg::pt_read_req_t seen_reads [$];
    vtp_pkg::pt_read_req_t exp_reads [$];

    always #(CLK_PERIOD / 2) clk = ~clk;

    vtp_top i_dut
    (
        .clk, .reset, .csr, .xlate_req, .xlate_req_data, .xlate_ack, .xlate_rsp,
        .pt_read_en, .pt_read_req, .pt_read_rdy, .pt_read_data_en, .pt_read_data
    );

    pt_mem_model i_mem
    (
        .clk, .reset, .read_en(pt_read_en), .read_req(pt_read_req), .read_rdy(pt_read_rdy),
        .read_data_en(pt_read_data_en), .read_data(pt_read_data)
    );

    // ====================
    // Table image
    // ====================

    function automatic logic [31:0] xorshift32(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic vtp_pkg::pa_page_idx_t table_page(int vid, int level);
        if (level == 0)
            return ROOT_PAGE;
        return vtp_pkg::pa_page_idx_t'(TABLE_PAGE_BASE + 4 * vid + level);
    endfunction

    // Level 0 takes the top 9 bits of the VA page number
    function automatic logic [8:0] level_idx(logic [47:0] va, int level);
        vtp_pkg::va_page_idx_t page;
        page = va[47:12];
        return page[vtp_pkg::VA_PAGE_IDX_WIDTH - 1 - 9 * level -: 9];
    endfunction

    // Level of the last read; the bad VA fails on its level 1 read
    function automatic int leaf_level(int vid);
        if (TEST_KIND[vid] == KIND_4KB)
            return 3;
        if (TEST_KIND[vid] == KIND_2MB)
            return 2;
        return 1;
    endfunction

    task automatic build_tables();
        logic [31:0] rng;
        logic [8:0] idx;
        vtp_pkg::pte_t entry;
        int last;
        rng = SEED;
        for (int vid = 0; vid < NUM_VAS; vid++)
        begin
            rng = xorshift32(rng);
            pa_list[vid] = {4'h1, rng};
            last = leaf_level(vid);
            for (int level = 0; level <= last; level++)
            begin
                idx = level_idx(TEST_VA[vid], level);
                entry = '0;
                if (level < last)
                begin
                    // Pointer to the next table page, line index zero
                    entry.line_addr = {table_page(vid, level + 1), 6'b0};
                    i_mem.set_entry({table_page(vid, level), idx[8:3]}, idx[2:0], entry);
                end
                else if (TEST_KIND[vid] != KIND_BAD)
                begin
                    entry.line_addr = {pa_list[vid], 6'b0};
                    entry.terminal = 1'b1;
                    i_mem.set_entry({table_page(vid, level), idx[8:3]}, idx[2:0], entry);
                end
            end
        end
    endtask

    // Lines a walk of this VA must read, root first
    task automatic expect_walk(int vid);
        logic [8:0] idx;
        vtp_pkg::pt_read_req_t req;
        for (int level = 0; level <= leaf_level(vid); level++)
        begin
            idx = level_idx(TEST_VA[vid], level);
            req.line_addr = {table_page(vid, level), idx[8:3]};
            exp_reads.push_back(req);
        end
    endtask

    // A 2 MB page takes its low 9 page bits from the VA
    function automatic vtp_pkg::xlate_rsp_t expect_rsp(logic [47:0] va, int vid);
        vtp_pkg::xlate_rsp_t rsp;
        rsp = '0;
        if (TEST_KIND[vid] == KIND_BAD)
        begin
            rsp.not_present = 1'b1;
        end
        else if (TEST_KIND[vid] == KIND_2MB)
        begin
            rsp.big_page = 1'b1;
            rsp.pa_page = {pa_list[vid][35:9], va[20:12]};
        end
        else
        begin
            rsp.pa_page = pa_list[vid];
        end
        return rsp;
    endfunction

    function automatic row_t make_row(logic [47:0] va, int vid, logic walk);
        row_t row;
        row.va = va;
        row.vid = 3'(vid);
        row.walk = walk;
        row.exp = expect_rsp(va, vid);
        return row;
    endfunction

    // ====================
    // Checks
    // ====================

    task automatic fail_run(string what);
        $display("%s", what);
        $display("Regression failed");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_rsp(vtp_pkg::xlate_rsp_t got, vtp_pkg::xlate_rsp_t exp, int row);
        if (got !== exp)
        begin
            fail_run($sformatf("MISMATCH at %0t ns: row %0d rsp %h/%b/%b expected %h/%b/%b",
                $time, row, got.pa_page, got.big_page, got.not_present,
                exp.pa_page, exp.big_page, exp.not_present));
        end
    endtask

    task automatic check_read(vtp_pkg::pt_read_req_t got, vtp_pkg::pt_read_req_t exp, int row);
        if (got !== exp)
        begin
            fail_run($sformatf("MISMATCH at %0t ns: row %0d read line %h expected %h",
                $time, row, got.line_addr, exp.line_addr));
        end
    endtask

    task automatic check_latency(int got, int exp, int row);
        if (got != exp)
        begin
            fail_run($sformatf("MISMATCH at %0t ns: row %0d ack after %0d cycles expected %0d",
                $time, row, got, exp));
        end
    endtask

    // Every accepted table read, in order
    initial
    begin
        forever
        begin
            @(negedge clk);
            if (!reset && pt_read_en && pt_read_rdy)
            begin
                seen_reads.push_back(pt_read_req);
            end
        end
    end

    // ====================
    // Stimulus
    // ====================

    task automatic run_row(int n);
        row_t row;
        int latency;
        int start;
        row = rows[n];
        exp_reads.delete();
        if (row.walk)
        begin
            expect_walk(int'(row.vid));
        end
        start = seen_reads.size();
        @(posedge clk);
        #1;
        xlate_req_data.va = row.va;
        xlate_req = 1'b1;
        // First edge that sees req high
        @(posedge clk);
        latency = 0;
        do
        begin
            @(posedge clk);
            latency++;
            @(negedge clk);
        end
        while (!xlate_ack);
        check_rsp(xlate_rsp, row.exp, n);
        if (!row.walk)
        begin
            check_latency(latency, HIT_LATENCY, n);
        end
        if (seen_reads.size() - start != exp_reads.size())
        begin
            fail_run($sformatf("Row %0d expected %0d table reads but saw %0d",
                n, exp_reads.size(), seen_reads.size() - start));
        end
        for (int i = 0; i < exp_reads.size(); i++)
        begin
            check_read(seen_reads[start + i], exp_reads[i], n);
        end
        @(posedge clk);
        #1;
        xlate_req = 1'b0;
        do
        begin
            @(negedge clk);
        end
        while (xlate_ack);
    endtask

    initial
    begin
        reset = 1'b1;
        csr = '{page_table_base: {ROOT_PAGE, 6'b0}, base_valid: 1'b1, enabled: 1'b1};
        xlate_req = 1'b0;
        xlate_req_data = '0;
        build_tables();
        // Cold miss, hit, 2 MB fill and alias hit, then round-robin eviction of VA 0
        rows[0] = make_row(TEST_VA[0], 0, 1'b1);
        rows[1] = make_row(TEST_VA[0], 0, 1'b0);
        rows[2] = make_row(TEST_VA[1], 1, 1'b1);
        rows[3] = make_row(VA_2MB_ALIAS, 1, 1'b0);
        rows[4] = make_row(TEST_VA[2], 2, 1'b1);
        rows[5] = make_row(TEST_VA[3], 3, 1'b1);
        rows[6] = make_row(TEST_VA[4], 4, 1'b1);
        rows[7] = make_row(TEST_VA[0], 0, 1'b1);
        // Invalid level 1 entry, then a hit and an unmapped VA after the error
        rows[8] = make_row(TEST_VA[5], 5, 1'b1);
        rows[9] = make_row(TEST_VA[0], 0, 1'b0);
        rows[10] = make_row(VA_UNMAPPED, 5, 1'b0);
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        for (int n = 0; n < NUM_ROWS; n++)
        begin
            run_row(n);
        end
        $display("Regression passed");
        $finish;
    end

    initial
    begin
        #(NUM_ROWS * CYCLES_PER_ROW * CLK_PERIOD);
        fail_run($sformatf("Timeout: the rows did not finish within %0d cycles",
            NUM_ROWS * CYCLES_PER_ROW));
    end

endmodule

`default_nettype wire

//--- vtp_top.f
hdl/vtp_pkg.sv
hdl/vtp_pt_walk.sv
hdl/vtp_tlb.sv
hdl/vtp_top.sv
tb/pt_mem_model.sv
tb/tb_vtp_top.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, and judge the run by the pass line in sim.log
rm -f sim.log
verilator --binary --assert --top-module tb_vtp_top -f vtp_top.f \
    -Mdir obj_dir -o vtp_sim \
    && ./obj_dir/vtp_sim 2>&1 | tee sim.log
grep -q "Regression passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
